// File: source/rv_config.svh
// Core widths, memory sizes and register reset constants
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath
`define RV_XLEN 64

// Register file
`define RV_REG_COUNT 32
`define RV_REG_AW 5

// Instruction memory, word addressed
`define RV_IMEM_WORDS 64
`define RV_IMEM_AW 6

// Stack pointer x2 after reset
`define RV_SP_RESET 128

`endif

// File: source/rv_pkg.sv
// Instruction word views, operation kinds and inter-stage structs
`include "rv_config.svh"

package rv_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0] funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0] funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0] opcode;
  } instr_i_t;

  // One fetched word, two decodings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [1:0] {
    none,
    reg_op,
    imm_op,
    lui_op
  } op_kind_e;

  typedef struct packed {
    op_kind_e kind;
    logic [2:0] funct3;
    logic alt; // Instruction bit 30
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_XLEN-1:0] imm; // Sign extended, or LUI upper value
  } dec_op_t;

  typedef struct packed {
    logic valid;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0] value;
  } wb_op_t;

  typedef struct packed {
    logic en;
    logic [`RV_REG_AW-1:0] addr;
    logic [`RV_XLEN-1:0] data;
  } reg_wr_t;

endpackage

// File: source/rv_fetch.sv
// Fetch stage with instruction memory, load port and program counter
`include "rv_config.svh"

module rv_fetch
  import rv_pkg::*;
(
  input  logic clk_div,
  input  logic reset,
  input  logic prog_we,
  input  logic [`RV_IMEM_AW-1:0] prog_addr,
  input  instr_u prog_data,
  input  logic stall,
  output instr_u instr,
  output logic instr_valid
);

  instr_u imem [`RV_IMEM_WORDS];
  logic [`RV_IMEM_AW-1:0] pc;

  // Program is loaded only while the core is held in reset
  always_ff @(posedge clk_div) begin
    if (!reset && prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      pc <= '0;
      instr_valid <= 1'b0;
    end else if (!stall) begin
      pc <= pc + 1'b1; // Wraps at end of memory
      instr_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_div) begin
    if (reset && !stall) begin
      instr <= imem[pc];
    end
  end

  // The load port belongs to the reset window only
  prog_we_in_reset: assert property (
    @(posedge clk_div) reset |-> !prog_we
  ) else $error("prog_we high outside reset");

endmodule

// File: source/rv_decode.sv
// Decode stage with field extraction, immediate build and hazard stall
`include "rv_config.svh"

module rv_decode
  import rv_pkg::*;
(
  input  logic clk_div,
  input  logic reset,
  input  instr_u instr,
  input  logic instr_valid,
  input  logic [`RV_REG_AW-1:0] exec_rd,
  input  logic exec_rd_valid,
  output logic stall,
  output dec_op_t op
);

  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;

  dec_op_t dec;
  logic use_rs1;
  logic use_rs2;
  logic rs1_hit;
  logic rs2_hit;

  always_comb begin
    dec = '0;
    dec.funct3 = instr.r.funct3;
    dec.rd = instr.r.rd;
    case (instr.r.opcode)
      OPC_REG: begin
        dec.kind = reg_op;
        dec.alt = instr.r.funct7[5];
        dec.rs1 = instr.r.rs1;
        dec.rs2 = instr.r.rs2;
      end
      OPC_IMM: begin
        dec.kind = imm_op;
        dec.alt = instr.i.imm12[10]; // SRAI select
        dec.rs1 = instr.i.rs1;
        dec.imm = {{(`RV_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
      end
      OPC_LUI: begin
        dec.kind = lui_op;
        dec.imm = {{(`RV_XLEN-32){instr.i.imm12[11]}}, instr.i.imm12,
                   instr.i.rs1, instr.i.funct3, 12'b0};
      end
      default: dec.kind = none; // Unknown opcode retires nothing
    endcase
    if (!instr_valid) begin
      dec.kind = none;
    end
  end

  // Only compare source fields the instruction really reads
  assign use_rs1 = (dec.kind == reg_op) || (dec.kind == imm_op);
  assign use_rs2 = (dec.kind == reg_op);
  assign rs1_hit = use_rs1 && (dec.rs1 == exec_rd);
  assign rs2_hit = use_rs2 && (dec.rs2 == exec_rd);
  assign stall = exec_rd_valid && (exec_rd != '0) && (rs1_hit || rs2_hit);

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      op <= '0;
    end else begin
      op <= dec;
      if (stall) begin
        op.kind <= none; // Bubble into execute
      end
    end
  end

  // Bubble clears the producer, so a stall never repeats
  stall_single_cycle: assert property (
    @(posedge clk_div) disable iff (!reset) stall |=> !stall
  ) else $error("stall held for two cycles");

endmodule

// File: source/rv_regfile.sv
// Integer register file with reset values and two combinational read ports
`include "rv_config.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic clk_div,
  input  logic reset,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  reg_wr_t wr,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  localparam logic [`RV_XLEN-1:0] SP_RESET = `RV_SP_RESET;

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= (i == 2) ? SP_RESET : '0; // x2 is the stack pointer
      end
    end else if (wr.en) begin
      regs[wr.addr] <= wr.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // Writeback must filter x0 destinations
  no_x0_write: assert property (
    @(posedge clk_div) disable iff (!reset) !(wr.en && (wr.addr == '0))
  ) else $error("register write to x0");

endmodule

// File: source/rv_execute.sv
// Execute stage with operand select, ALU and execute-to-writeback register
`include "rv_config.svh"

module rv_execute
  import rv_pkg::*;
(
  input  logic clk_div,
  input  logic reset,
  input  dec_op_t op,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_REG_AW-1:0] rs1,
  output logic [`RV_REG_AW-1:0] rs2,
  output logic [`RV_REG_AW-1:0] exec_rd,
  output logic exec_rd_valid,
  output wb_op_t wb
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [5:0] shamt;
  logic [`RV_XLEN-1:0] alu;

  // Register file read addresses
  assign rs1 = op.rs1;
  assign rs2 = op.rs2;

  // Producer seen by the hazard check in decode
  assign exec_rd = op.rd;
  assign exec_rd_valid = (op.kind != none);

  assign op_a = rs1_data;
  assign op_b = (op.kind == reg_op) ? rs2_data : op.imm;
  assign shamt = op_b[5:0];

  always_comb begin
    case (op.funct3)
      3'b000: begin
        if ((op.kind == reg_op) && op.alt) begin
          alu = op_a - op_b; // SUB
        end else begin
          alu = op_a + op_b;
        end
      end
      3'b001: alu = op_a << shamt;
      3'b010: alu = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      3'b011: alu = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      3'b100: alu = op_a ^ op_b;
      3'b101: begin
        if (op.alt) begin
          alu = $unsigned($signed(op_a) >>> shamt); // SRA, SRAI
        end else begin
          alu = op_a >> shamt;
        end
      end
      3'b110: alu = op_a | op_b;
      default: alu = op_a & op_b;
    endcase
    if (op.kind == lui_op) begin
      alu = op.imm;
    end
  end

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      wb <= '0;
    end else begin
      wb.valid <= (op.kind != none);
      wb.rd <= op.rd;
      wb.value <= alu;
    end
  end

endmodule

// File: source/rv_writeback.sv
// Writeback stage with register write and registered result output
`include "rv_config.svh"

module rv_writeback
  import rv_pkg::*;
(
  input  logic clk_div,
  input  logic reset,
  input  wb_op_t wb,
  output reg_wr_t wr,
  output logic [`RV_XLEN-1:0] result,
  output logic result_valid
);

  logic rd_nonzero;

  assign rd_nonzero = (wb.rd != '0);

  // Commit lands on the same edge the consumer enters execute
  assign wr.en = wb.valid && rd_nonzero;
  assign wr.addr = wb.rd;
  assign wr.data = wb.value;

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      result <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= wb.valid;
      if (wb.valid) begin
        result <= rd_nonzero ? wb.value : '0; // x0 reports zero
      end
    end
  end

endmodule

// File: source/rv_core.sv
// Top level of the four-stage RV64I integer core
`include "rv_config.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic clk_div,
  input  logic reset,
  input  logic prog_we,
  input  logic [`RV_IMEM_AW-1:0] prog_addr,
  input  instr_u prog_data,
  output logic [`RV_XLEN-1:0] result,
  output logic result_valid
);

  instr_u instr;
  logic instr_valid;
  logic stall;
  dec_op_t op;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] exec_rd;
  logic exec_rd_valid;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  wb_op_t wb;
  reg_wr_t wr;

  rv_fetch fetch_i (
    .clk_div     (clk_div),
    .reset       (reset),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .stall       (stall),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  rv_decode decode_i (
    .clk_div       (clk_div),
    .reset         (reset),
    .instr         (instr),
    .instr_valid   (instr_valid),
    .exec_rd       (exec_rd),
    .exec_rd_valid (exec_rd_valid),
    .stall         (stall),
    .op            (op)
  );

  rv_regfile regfile_i (
    .clk_div  (clk_div),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr       (wr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute execute_i (
    .clk_div       (clk_div),
    .reset         (reset),
    .op            (op),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .rs1           (rs1),
    .rs2           (rs2),
    .exec_rd       (exec_rd),
    .exec_rd_valid (exec_rd_valid),
    .wb            (wb)
  );

  rv_writeback writeback_i (
    .clk_div      (clk_div),
    .reset        (reset),
    .wb           (wb),
    .wr           (wr),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// File: tb/rv_tb_model.svh
// Instruction encoders, program generators, reference ISA model and compare task
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

task automatic clear_program();
  foreach (prog_words[k]) begin
    prog_words[k] = '0; // Zero words decode as unknown and retire nothing
  end
  prog_len = 0;
  last_rd = '0;
endtask

task automatic emit(input logic [31:0] word);
  prog_words[prog_len] = word;
  prog_len++;
  last_rd = word[11:7];
endtask

// Any source except the destination just written
function automatic logic [4:0] pick_source();
  logic [4:0] r;
  r = 5'($urandom_range(31, 0));
  while (last_rd != '0 && r == last_rd) begin
    r = 5'($urandom_range(31, 0));
  end
  return r;
endfunction

task automatic gen_r_program(input int seeds, input int count);
  logic [2:0] f3;
  logic [6:0] f7;
  logic [4:0] rd;
  clear_program();
  for (int k = 0; k < seeds; k++) begin
    rd = (k == 0) ? 5'd1 : 5'(k + 2); // x2 keeps its reset value
    emit(enc_i(12'($urandom), 5'd0, 3'd0, rd));
  end
  for (int k = 0; k < count; k++) begin
    f3 = 3'($urandom_range(7, 0));
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
    rd = 5'($urandom_range(31, 0));
    emit(enc_r(f7, pick_source(), pick_source(), f3, rd));
  end
endtask

task automatic gen_i_program(input int count, input bit chain);
  logic [2:0] f3;
  logic [11:0] imm;
  logic [4:0] rs1;
  logic [4:0] rd;
  clear_program();
  for (int k = 0; k < count; k++) begin
    rd = 5'($urandom_range(31, 1));
    rs1 = (chain && last_rd != '0) ? last_rd : 5'($urandom_range(31, 0));
    f3 = 3'($urandom_range(7, 0));
    imm = 12'($urandom);
    if (f3 == 3'd1) imm[11:6] = 6'b000000;
    if (f3 == 3'd5) imm[11:6] = {1'b0, imm[10], 4'b0000}; // SRLI or SRAI
    if ($urandom_range(5, 0) == 0) begin
      emit(enc_lui(20'($urandom), rd));
    end else begin
      emit(enc_i(imm, rs1, f3, rd));
    end
  end
endtask

task automatic gen_x0_program();
  clear_program();
  emit(enc_i(12'd0, 5'd2, 3'd0, 5'd5)); // Reads x2 before any write
  emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd0));
  emit(enc_r(7'h00, 5'd5, 5'd2, 3'd0, 5'd0));
  emit(enc_lui(20'habcde, 5'd0));
  emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd6)); // x0 must still be zero
  emit(enc_r(7'h00, 5'd5, 5'd0, 3'd3, 5'd7));
  emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd8));
  emit(enc_r(7'h20, 5'd0, 5'd2, 3'd0, 5'd9));
endtask

function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input logic [63:0] a,
                                        input logic [63:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic [5:0] sh;
  sa = a;
  sb = b;
  sh = b[5:0];
  case (f3)
    3'd0: alu_ref = (is_reg && alt) ? a - b : a + b;
    3'd1: alu_ref = a << sh;
    3'd2: alu_ref = (sa < sb) ? 64'd1 : 64'd0;
    3'd3: alu_ref = (a < b) ? 64'd1 : 64'd0;
    3'd4: alu_ref = a ^ b;
    3'd5: begin
      if (alt) alu_ref = sa >>> sh;
      else alu_ref = a >> sh;
    end
    3'd6: alu_ref = a | b;
    default: alu_ref = a & b;
  endcase
endfunction

// Runs the loaded program in order and queues one result per known opcode
function automatic void run_reference();
  logic [63:0] regs [32];
  logic [31:0] w;
  logic [63:0] val;
  logic known;
  for (int r = 0; r < 32; r++) begin
    regs[r] = (r == 2) ? 64'd128 : 64'd0;
  end
  expected_q.delete();
  for (int k = 0; k < prog_len; k++) begin
    w = prog_words[k];
    known = 1'b1;
    case (w[6:0])
      7'b0110011: val = alu_ref(w[14:12], w[30], 1'b1, regs[w[19:15]], regs[w[24:20]]);
      7'b0010011: val = alu_ref(w[14:12], w[30], 1'b0, regs[w[19:15]],
                                {{52{w[31]}}, w[31:20]});
      7'b0110111: val = {{32{w[31]}}, w[31:12], 12'h000};
      default: known = 1'b0;
    endcase
    if (known) begin
      if (w[11:7] != 5'd0) regs[w[11:7]] = val;
      expected_q.push_back((w[11:7] != 5'd0) ? val : 64'd0);
    end
  end
endfunction

task automatic check_value(input string what, input logic [63:0] got,
                           input logic [63:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

`endif

// File: tb/rv_core_tb.sv
// Testbench for the RV64I core with program load, result checker and test sequence
`include "rv_config.svh"

module rv_core_tb
  import rv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 8;
  localparam int LOAD_CYCLES = `RV_IMEM_WORDS + 1;
  localparam int R_SEEDS = 8;
  localparam int R_BODY = 24;
  localparam int I_LEN = 28;
  localparam int X0_LEN = 8;
  localparam int RST_LEN = 20;
  localparam int TOTAL_INSTR = R_SEEDS + R_BODY + I_LEN + X0_LEN + 2 * RST_LEN;
  localparam int CYCLE_LIMIT = 2 * TOTAL_INSTR + 4 * LOAD_CYCLES + RESET_CYCLES + 100;

  logic clk_div;
  logic reset;
  logic prog_we;
  logic [`RV_IMEM_AW-1:0] prog_addr;
  instr_u prog_data;
  logic [`RV_XLEN-1:0] result;
  logic result_valid;

  logic [31:0] prog_words [`RV_IMEM_WORDS];
  int prog_len = 0;
  logic [4:0] last_rd = '0;
  logic [`RV_XLEN-1:0] expected_q [$];
  int error_count = 0;
  int check_count = 0;
  int results_seen = 0;
  int cycle_count = 0;
  int test_num = 0;
  int test_err_base = 0;
  logic rst_q1 = 1'b0; // Reset as the DUT saw it one and two edges back
  logic rst_q2 = 1'b0;

  `include "rv_tb_model.svh"

  rv_core dut_i (
    .clk_div      (clk_div),
    .reset        (reset),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result       (result),
    .result_valid (result_valid)
  );

  initial begin
    clk_div = 1'b0;
    forever #2 clk_div = ~clk_div;
  end

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_div);
      cycle_count++;
    end
    $display("Run stopped: cycle limit of %0d reached before all results arrived",
             CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  // Outputs sampled mid-cycle, away from the active edge
  initial begin
    @(posedge clk_div);
    forever begin
      @(negedge clk_div);
      if (!rst_q1 || !rst_q2) begin
        check_value("result_valid near reset", 64'(result_valid), 64'd0);
        check_value("result near reset", result, 64'd0);
      end else if (result_valid) begin
        results_seen++;
        if (expected_q.size() == 0) begin
          error_count++;
          $display("Unexpected result %h at %0t ns with no instruction left to retire",
                   result, $time);
        end else begin
          check_value("result", result, expected_q.pop_front());
        end
      end
      rst_q2 = rst_q1;
      rst_q1 = reset;
    end
  end

  // Rewrites every word so nothing of the last program is left
  task automatic load_program();
    @(posedge clk_div);
    reset <= 1'b0;
    for (int a = 0; a < `RV_IMEM_WORDS; a++) begin
      prog_we <= 1'b1;
      prog_addr <= a[`RV_IMEM_AW-1:0];
      prog_data <= prog_words[a];
      @(posedge clk_div);
    end
    prog_we <= 1'b0;
    reset <= 1'b1;
  endtask

  task automatic wait_results();
    while (expected_q.size() != 0) begin
      @(posedge clk_div);
    end
    repeat (DRAIN_CYCLES) @(posedge clk_div); // Catch stray pulses
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("Test %0d %s: %s, %0d errors", test_num, name,
             (error_count == test_err_base) ? "ok" : "failed", error_count - test_err_base);
    test_err_base = error_count;
  endtask

  initial begin
    int mark;
    reset = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(32'h97235a4f));

    gen_r_program(R_SEEDS, R_BODY);
    run_reference();
    load_program();
    repeat (2) @(posedge clk_div);
    finish_test("outputs clear in reset");
    wait_results();
    finish_test("R-type without dependencies");

    gen_i_program(I_LEN, 1'b1);
    run_reference();
    load_program();
    wait_results();
    finish_test("I-type chains with stalls");

    gen_x0_program();
    run_reference();
    load_program();
    wait_results();
    finish_test("x0 writes and x2 reset value");

    gen_r_program(4, RST_LEN - 4);
    prog_words[0] = enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd1); // Reads x1 before writing it
    run_reference();
    load_program();
    mark = results_seen + 8;
    while (results_seen < mark) begin
      @(posedge clk_div);
    end
    @(posedge clk_div);
    reset <= 1'b0; // Program stays in memory
    repeat (RESET_CYCLES) @(posedge clk_div);
    run_reference();
    reset <= 1'b1;
    wait_results();
    finish_test("reset in mid run");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_num, check_count,
             error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+source
+incdir+tb
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_writeback.sv
source/rv_core.sv
tb/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/rv_fetch.sv
      - source/rv_decode.sv
      - source/rv_regfile.sv
      - source/rv_execute.sv
      - source/rv_writeback.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/rv_core_tb.sv
